//--- design/candidate_builder.sv
module candidate_builder (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  chase_pkg::err_cnt_t i_num_err,
    input  chase_pkg::tp_cnt_t  i_num_tp,
    input  chase_pkg::pos_t     i_err_loc0,
    input  chase_pkg::pos_t     i_err_loc1,
    input  chase_pkg::pos_t     i_err_loc2,
    input  chase_pkg::pos_t     i_err_loc3,
    input  chase_pkg::pos_t     i_flip_pos1,
    input  chase_pkg::pos_t     i_flip_pos2,
    output chase_pkg::pos_t     o_sorted0,
    output chase_pkg::pos_t     o_sorted1,
    output chase_pkg::pos_t     o_sorted2,
    output chase_pkg::pos_t     o_sorted3,
    output chase_pkg::pos_t     o_sorted4,
    output chase_pkg::pos_t     o_sorted5,
    output chase_pkg::err_cnt_t o_cand_cnt,
    output chase_pkg::pos_t     o_llr_addr0,
    output chase_pkg::pos_t     o_llr_addr1,
    output chase_pkg::pos_t     o_llr_addr2,
    output chase_pkg::pos_t     o_llr_addr3,
    output chase_pkg::pos_t     o_llr_addr4,
    output chase_pkg::pos_t     o_llr_addr5
);

    import chase_pkg::*;

    pos_t                loc [MAX_ERR];
    pos_t                cand [NUM_CAND];
    pos_t                addr_q [NUM_CAND];
    logic [NUM_FLIP-1:0] flips;

    assign loc[0] = i_err_loc0;
    assign loc[1] = i_err_loc1;
    assign loc[2] = i_err_loc2;
    assign loc[3] = i_err_loc3;
    assign flips  = flip_sel(i_num_tp);

    always_comb begin
        for (int i = 0; i < MAX_ERR; i++) begin
            cand[i] = (i < i_num_err) ? loc[i] : POS_NONE;
        end
        cand[MAX_ERR]   = flips[0] ? i_flip_pos1 : POS_NONE;
        cand[MAX_ERR+1] = flips[1] ? i_flip_pos2 : POS_NONE;
    end

    assign o_cand_cnt = i_num_err + err_cnt_t'(flips[0]) + err_cnt_t'(flips[1]);

    // Unsorted slot order is kept on the address side so the scorer can mask by slot.
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < NUM_CAND; i++) begin
            addr_q[i] <= i_rst_n ? cand[i] : POS_NONE;
        end
    end

    assign o_llr_addr0 = addr_q[0];
    assign o_llr_addr1 = addr_q[1];
    assign o_llr_addr2 = addr_q[2];
    assign o_llr_addr3 = addr_q[3];
    assign o_llr_addr4 = addr_q[4];
    assign o_llr_addr5 = addr_q[5];

    position_sorter u_sorter (
        .i_pos0 (cand[0]),
        .i_pos1 (cand[1]),
        .i_pos2 (cand[2]),
        .i_pos3 (cand[3]),
        .i_pos4 (cand[4]),
        .i_pos5 (cand[5]),
        .o_pos0 (o_sorted0),
        .o_pos1 (o_sorted1),
        .o_pos2 (o_sorted2),
        .o_pos3 (o_sorted3),
        .o_pos4 (o_sorted4),
        .o_pos5 (o_sorted5)
    );

    a_num_err_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) i_num_err <= MAX_ERR
    );

endmodule

//--- design/chase_pattern_saver.sv
module chase_pattern_saver (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_mode,
    input  logic                i_clear,
    input  logic                i_err_valid_pulse,
    input  chase_pkg::pos_t     i_err_loc0,
    input  chase_pkg::pos_t     i_err_loc1,
    input  chase_pkg::pos_t     i_err_loc2,
    input  chase_pkg::pos_t     i_err_loc3,
    input  chase_pkg::err_cnt_t i_num_err,
    input  logic                i_correct,
    input  chase_pkg::pos_t     i_flip_pos1,
    input  chase_pkg::pos_t     i_flip_pos2,
    input  logic                i_flip_valid,
    output chase_pkg::pos_t     o_llr_addr0,
    output chase_pkg::pos_t     o_llr_addr1,
    output chase_pkg::pos_t     o_llr_addr2,
    output chase_pkg::pos_t     o_llr_addr3,
    output chase_pkg::pos_t     o_llr_addr4,
    output chase_pkg::pos_t     o_llr_addr5,
    input  chase_pkg::llr_t     i_llr0,
    input  chase_pkg::llr_t     i_llr1,
    input  chase_pkg::llr_t     i_llr2,
    input  chase_pkg::llr_t     i_llr3,
    input  chase_pkg::llr_t     i_llr4,
    input  chase_pkg::llr_t     i_llr5,
    input  chase_pkg::tp_idx_t  i_rd_sel,
    output chase_pkg::pos_t     o_rd_pos0,
    output chase_pkg::pos_t     o_rd_pos1,
    output chase_pkg::pos_t     o_rd_pos2,
    output chase_pkg::pos_t     o_rd_pos3,
    output chase_pkg::pos_t     o_rd_pos4,
    output chase_pkg::pos_t     o_rd_pos5,
    output chase_pkg::err_cnt_t o_rd_cnt,
    output chase_pkg::tp_cnt_t  o_min_tp,
    output logic                o_valid
);

    import chase_pkg::*;

    tp_cnt_t  num_tp;
    logic     store_en;
    tp_idx_t  store_idx;
    logic     score_en;
    logic     score_clr;
    err_cnt_t num_err_dly;
    tp_cnt_t  num_tp_dly;
    tp_idx_t  store_idx_dly;
    pos_t     sorted0, sorted1, sorted2, sorted3, sorted4, sorted5;
    err_cnt_t cand_cnt;

    pattern_counter u_counter (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_mode (i_mode), .i_clear (i_clear),
        .i_err_valid_pulse (i_err_valid_pulse), .i_correct (i_correct),
        .i_flip_valid (i_flip_valid), .i_num_err (i_num_err), .o_num_tp (num_tp),
        .o_store_en (store_en), .o_store_idx (store_idx), .o_score_en (score_en),
        .o_score_clr (score_clr), .o_num_err_dly (num_err_dly), .o_num_tp_dly (num_tp_dly),
        .o_store_idx_dly (store_idx_dly), .o_valid (o_valid)
    );

    candidate_builder u_builder (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_num_err (i_num_err), .i_num_tp (num_tp),
        .i_err_loc0 (i_err_loc0), .i_err_loc1 (i_err_loc1), .i_err_loc2 (i_err_loc2),
        .i_err_loc3 (i_err_loc3), .i_flip_pos1 (i_flip_pos1), .i_flip_pos2 (i_flip_pos2),
        .o_sorted0 (sorted0), .o_sorted1 (sorted1), .o_sorted2 (sorted2),
        .o_sorted3 (sorted3), .o_sorted4 (sorted4), .o_sorted5 (sorted5),
        .o_cand_cnt (cand_cnt),
        .o_llr_addr0 (o_llr_addr0), .o_llr_addr1 (o_llr_addr1), .o_llr_addr2 (o_llr_addr2),
        .o_llr_addr3 (o_llr_addr3), .o_llr_addr4 (o_llr_addr4), .o_llr_addr5 (o_llr_addr5)
    );

    pattern_store u_store (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_store_en (store_en),
        .i_store_idx (store_idx), .i_sorted0 (sorted0), .i_sorted1 (sorted1),
        .i_sorted2 (sorted2), .i_sorted3 (sorted3), .i_sorted4 (sorted4),
        .i_sorted5 (sorted5), .i_cand_cnt (cand_cnt), .i_rd_sel (i_rd_sel),
        .o_rd_pos0 (o_rd_pos0), .o_rd_pos1 (o_rd_pos1), .o_rd_pos2 (o_rd_pos2),
        .o_rd_pos3 (o_rd_pos3), .o_rd_pos4 (o_rd_pos4), .o_rd_pos5 (o_rd_pos5),
        .o_rd_cnt (o_rd_cnt)
    );

    llr_min_tracker u_tracker (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_score_en (score_en),
        .i_score_clr (score_clr), .i_num_err_dly (num_err_dly), .i_num_tp_dly (num_tp_dly),
        .i_store_idx_dly (store_idx_dly), .i_llr0 (i_llr0), .i_llr1 (i_llr1),
        .i_llr2 (i_llr2), .i_llr3 (i_llr3), .i_llr4 (i_llr4), .i_llr5 (i_llr5),
        .o_min_tp (o_min_tp)
    );

endmodule

//--- design/chase_pkg.sv
package chase_pkg;

    typedef logic [9:0] pos_t;      // Bit position inside the codeword.
    typedef logic [6:0] llr_t;      // Reliability magnitude of one bit.
    typedef logic [9:0] llr_sum_t;  // Six LLRs added, at most 762.
    typedef logic [2:0] err_cnt_t;
    typedef logic [2:0] tp_cnt_t;
    typedef logic [1:0] tp_idx_t;

    localparam int MAX_ERR     = 4;
    localparam int NUM_FLIP    = 2;
    localparam int NUM_CAND    = MAX_ERR + NUM_FLIP;
    localparam int NUM_TP      = 4;
    localparam int SCORE_DELAY = 2;

    localparam pos_t     POS_NONE     = '1; // Unused candidate, sorts last.
    localparam llr_sum_t LLR_SUM_INIT = '1;

    // Pattern 1 flips the first position, pattern 2 the second, pattern 3 both.
    function automatic logic [NUM_FLIP-1:0] flip_sel(tp_cnt_t num_tp);
        case (num_tp)
            3'd1:    flip_sel = 2'b01;
            3'd2:    flip_sel = 2'b10;
            3'd3:    flip_sel = 2'b11;
            default: flip_sel = 2'b00;
        endcase
    endfunction

endpackage

//--- design/llr_min_tracker.sv
module llr_min_tracker (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_score_en,
    input  logic                i_score_clr,
    input  chase_pkg::err_cnt_t i_num_err_dly,
    input  chase_pkg::tp_cnt_t  i_num_tp_dly,
    input  chase_pkg::tp_idx_t  i_store_idx_dly,
    input  chase_pkg::llr_t     i_llr0,
    input  chase_pkg::llr_t     i_llr1,
    input  chase_pkg::llr_t     i_llr2,
    input  chase_pkg::llr_t     i_llr3,
    input  chase_pkg::llr_t     i_llr4,
    input  chase_pkg::llr_t     i_llr5,
    output chase_pkg::tp_cnt_t  o_min_tp
);

    import chase_pkg::*;

    llr_t                llr_in [NUM_CAND];
    llr_t                llr_m [NUM_CAND];
    logic [NUM_FLIP-1:0] flips;
    llr_sum_t            llr_sum;
    llr_sum_t            min_sum;
    tp_cnt_t             min_tp;

    assign llr_in[0] = i_llr0;
    assign llr_in[1] = i_llr1;
    assign llr_in[2] = i_llr2;
    assign llr_in[3] = i_llr3;
    assign llr_in[4] = i_llr4;
    assign llr_in[5] = i_llr5;
    assign flips     = flip_sel(i_num_tp_dly);

    // Same slot masking as on the address side, replayed on the delayed counts.
    always_comb begin
        for (int i = 0; i < MAX_ERR; i++) begin
            llr_m[i] = (i < i_num_err_dly) ? llr_in[i] : '0;
        end
        llr_m[MAX_ERR]   = flips[0] ? llr_in[MAX_ERR] : '0;
        llr_m[MAX_ERR+1] = flips[1] ? llr_in[MAX_ERR+1] : '0;
    end

    assign llr_sum = llr_sum_t'(llr_m[0]) + llr_sum_t'(llr_m[1]) + llr_sum_t'(llr_m[2])
                   + llr_sum_t'(llr_m[3]) + llr_sum_t'(llr_m[4]) + llr_sum_t'(llr_m[5]);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_score_clr) begin
            min_sum <= LLR_SUM_INIT;
            min_tp  <= '0;
        end else if (i_score_en && llr_sum < min_sum) begin // Strict so the earliest slot keeps a tie.
            min_sum <= llr_sum;
            min_tp  <= tp_cnt_t'(i_store_idx_dly) + tp_cnt_t'(1);
        end
    end

    assign o_min_tp = min_tp;

    a_num_err_dly_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_score_en |-> i_num_err_dly <= MAX_ERR
    );

endmodule

//--- design/pattern_counter.sv
module pattern_counter (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_mode,
    input  logic                i_clear,
    input  logic                i_err_valid_pulse,
    input  logic                i_correct,
    input  logic                i_flip_valid,
    input  chase_pkg::err_cnt_t i_num_err,
    output chase_pkg::tp_cnt_t  o_num_tp,
    output logic                o_store_en,
    output chase_pkg::tp_idx_t  o_store_idx,
    output logic                o_score_en,
    output logic                o_score_clr,
    output chase_pkg::err_cnt_t o_num_err_dly,
    output chase_pkg::tp_cnt_t  o_num_tp_dly,
    output chase_pkg::tp_idx_t  o_store_idx_dly,
    output logic                o_valid
);

    import chase_pkg::*;

    tp_cnt_t                num_tp;
    tp_cnt_t                num_valid_tp;
    logic                   accept;
    logic [SCORE_DELAY-1:0] pulse_sr;
    logic [SCORE_DELAY-1:0] correct_sr;
    logic [SCORE_DELAY-1:0] flip_sr;
    logic [SCORE_DELAY-1:0] valid_sr;
    err_cnt_t               num_err_sr [SCORE_DELAY];
    tp_cnt_t                num_tp_sr [SCORE_DELAY];
    tp_idx_t                idx_sr [SCORE_DELAY];

    // A pulse is taken only under mode, without a clear, while a slot is still free.
    assign accept = i_mode & i_err_valid_pulse & ~i_clear & (num_valid_tp < NUM_TP);

    assign o_store_en  = accept & i_correct & i_flip_valid;
    assign o_store_idx = tp_idx_t'(num_valid_tp);
    assign o_num_tp    = num_tp;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            num_tp       <= '0;
            num_valid_tp <= '0;
        end else if (i_mode) begin
            if (i_clear) begin
                num_tp       <= '0;
                num_valid_tp <= '0;
            end else if (i_err_valid_pulse) begin
                if (num_tp < NUM_TP)
                    num_tp <= num_tp + tp_cnt_t'(1);
                if (o_store_en)
                    num_valid_tp <= num_valid_tp + tp_cnt_t'(1);
            end
        end
    end

    // Qualifier pipeline runs regardless of mode.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pulse_sr   <= '0;
            correct_sr <= '0;
            flip_sr    <= '0;
            valid_sr   <= '0;
        end else begin
            pulse_sr   <= {pulse_sr[SCORE_DELAY-2:0], accept};
            correct_sr <= {correct_sr[SCORE_DELAY-2:0], i_correct};
            flip_sr    <= {flip_sr[SCORE_DELAY-2:0], i_flip_valid};
            valid_sr   <= {valid_sr[SCORE_DELAY-2:0], num_tp == NUM_TP};
        end
    end

    always_ff @(posedge i_clk) begin
        num_err_sr[0] <= i_num_err;
        num_tp_sr[0]  <= num_tp;
        idx_sr[0]     <= o_store_idx;
        for (int i = 1; i < SCORE_DELAY; i++) begin
            num_err_sr[i] <= num_err_sr[i-1];
            num_tp_sr[i]  <= num_tp_sr[i-1];
            idx_sr[i]     <= idx_sr[i-1];
        end
    end

    assign o_score_en = i_mode & pulse_sr[SCORE_DELAY-1] & correct_sr[SCORE_DELAY-1]
                      & flip_sr[SCORE_DELAY-1];
    assign o_score_clr     = i_mode & i_clear;
    assign o_num_err_dly   = num_err_sr[SCORE_DELAY-1];
    assign o_num_tp_dly    = num_tp_sr[SCORE_DELAY-1];
    assign o_store_idx_dly = idx_sr[SCORE_DELAY-1];
    assign o_valid         = valid_sr[SCORE_DELAY-1];

    a_valid_le_total: assert property (
        @(posedge i_clk) disable iff (!i_rst_n) num_valid_tp <= num_tp
    );

endmodule

//--- design/pattern_store.sv
module pattern_store (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_store_en,
    input  chase_pkg::tp_idx_t  i_store_idx,
    input  chase_pkg::pos_t     i_sorted0,
    input  chase_pkg::pos_t     i_sorted1,
    input  chase_pkg::pos_t     i_sorted2,
    input  chase_pkg::pos_t     i_sorted3,
    input  chase_pkg::pos_t     i_sorted4,
    input  chase_pkg::pos_t     i_sorted5,
    input  chase_pkg::err_cnt_t i_cand_cnt,
    input  chase_pkg::tp_idx_t  i_rd_sel,
    output chase_pkg::pos_t     o_rd_pos0,
    output chase_pkg::pos_t     o_rd_pos1,
    output chase_pkg::pos_t     o_rd_pos2,
    output chase_pkg::pos_t     o_rd_pos3,
    output chase_pkg::pos_t     o_rd_pos4,
    output chase_pkg::pos_t     o_rd_pos5,
    output chase_pkg::err_cnt_t o_rd_cnt
);

    import chase_pkg::*;

    pos_t     mem_pos [NUM_TP][NUM_CAND];
    err_cnt_t mem_cnt [NUM_TP];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int t = 0; t < NUM_TP; t++) begin
                mem_cnt[t] <= '0;
                for (int c = 0; c < NUM_CAND; c++) begin
                    mem_pos[t][c] <= '0;
                end
            end
        end else if (i_store_en) begin
            mem_pos[i_store_idx][0] <= i_sorted0;
            mem_pos[i_store_idx][1] <= i_sorted1;
            mem_pos[i_store_idx][2] <= i_sorted2;
            mem_pos[i_store_idx][3] <= i_sorted3;
            mem_pos[i_store_idx][4] <= i_sorted4;
            mem_pos[i_store_idx][5] <= i_sorted5;
            mem_cnt[i_store_idx]    <= i_cand_cnt;
        end
    end

    assign o_rd_pos0 = mem_pos[i_rd_sel][0]; // Read port is combinational.
    assign o_rd_pos1 = mem_pos[i_rd_sel][1];
    assign o_rd_pos2 = mem_pos[i_rd_sel][2];
    assign o_rd_pos3 = mem_pos[i_rd_sel][3];
    assign o_rd_pos4 = mem_pos[i_rd_sel][4];
    assign o_rd_pos5 = mem_pos[i_rd_sel][5];
    assign o_rd_cnt  = mem_cnt[i_rd_sel];

endmodule

//--- design/position_sorter.sv
module position_sorter (
    input  chase_pkg::pos_t i_pos0,
    input  chase_pkg::pos_t i_pos1,
    input  chase_pkg::pos_t i_pos2,
    input  chase_pkg::pos_t i_pos3,
    input  chase_pkg::pos_t i_pos4,
    input  chase_pkg::pos_t i_pos5,
    output chase_pkg::pos_t o_pos0,
    output chase_pkg::pos_t o_pos1,
    output chase_pkg::pos_t o_pos2,
    output chase_pkg::pos_t o_pos3,
    output chase_pkg::pos_t o_pos4,
    output chase_pkg::pos_t o_pos5
);

    import chase_pkg::*;

    pos_t v [NUM_CAND];

    // Each outer pass sinks one new element into the already ordered prefix.
    always_comb begin : insert_net
        pos_t tmp;
        tmp  = '0;
        v[0] = i_pos0;
        v[1] = i_pos1;
        v[2] = i_pos2;
        v[3] = i_pos3;
        v[4] = i_pos4;
        v[5] = i_pos5;
        for (int i = 1; i < NUM_CAND; i++) begin
            for (int j = i; j > 0; j--) begin
                if (v[j-1] > v[j]) begin // Compare-exchange.
                    tmp    = v[j-1];
                    v[j-1] = v[j];
                    v[j]   = tmp;
                end
            end
        end
    end

    assign o_pos0 = v[0];
    assign o_pos1 = v[1];
    assign o_pos2 = v[2];
    assign o_pos3 = v[3];
    assign o_pos4 = v[4];
    assign o_pos5 = v[5];

endmodule

//--- src.f
design/chase_pkg.sv
design/position_sorter.sv
design/candidate_builder.sv
design/pattern_counter.sv
design/pattern_store.sv
design/llr_min_tracker.sv
design/chase_pattern_saver.sv
verification/tb_chase_pattern_saver.sv

//--- verification/tb_chase_pattern_saver.sv
module tb_chase_pattern_saver;

    import chase_pkg::*;

    localparam int NUM_ROWS = 7;
    localparam int NUM_PAT  = NUM_ROWS * NUM_TP;
    localparam int CLK_HALF = 20;

    // One entry per pattern, four patterns per codeword row.
    int tbl_ne  [NUM_PAT] = '{3, 2, 4, 4, 2, 1, 3, 0, 3, 2, 4, 4, 0, 0, 0, 0, 2, 2, 1, 3, 1, 0, 2, 0,
                              1, 2, 3, 4};
    int tbl_l0  [NUM_PAT] = '{300, 500, 1, 9, 40, 600, 256, 17, 300, 500, 1, 9,
                              0, 0, 0, 0, 5, 6, 7, 8, 10, 44, 3, 55, 11, 12, 13, 14};
    int tbl_l1  [NUM_PAT] = '{12, 20, 2, 600, 30, 71, 128, 18, 12, 20, 2, 600,
                              0, 0, 0, 0, 15, 16, 17, 18, 66, 77, 7, 88, 21, 22, 23, 24};
    int tbl_l2  [NUM_PAT] = '{700, 811, 3, 33, 62, 72, 384, 19, 700, 811, 3, 33,
                              0, 0, 0, 0, 25, 26, 27, 28, 99, 101, 102, 103, 31, 32, 33, 34};
    int tbl_l3  [NUM_PAT] = '{0, 2, 1000, 1, 63, 73, 83, 20, 0, 2, 1000, 1,
                              0, 0, 0, 0, 35, 36, 37, 38, 104, 105, 106, 107, 41, 42, 43, 44};
    int tbl_f1  [NUM_PAT] = '{45, 5, 77, 8, 11, 3, 50, 90, 45, 5, 77, 8,
                              0, 0, 0, 0, 1, 2, 3, 4, 0, 138, 0, 200, 51, 52, 53, 54};
    int tbl_f2  [NUM_PAT] = '{900, 999, 64, 7, 22, 4, 60, 91, 900, 999, 64, 7,
                              0, 0, 0, 0, 9, 10, 11, 12, 0, 0, 0, 300, 61, 62, 63, 64};
    int tbl_ok  [NUM_PAT] = '{1, 1, 1, 1, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1,
                              0, 1, 0, 1};
    int tbl_fv  [NUM_PAT] = '{1, 1, 1, 1, 1, 0, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1, 1,
                              1, 0, 1, 0};
    int tbl_gap [NUM_PAT] = '{3, 3, 3, 3, 2, 0, 4, 1, 0, 0, 0, 0, 1, 0, 2, 0, 2, 2, 2, 2, 0, 0, 0, 0,
                              1, 1, 1, 1};
    int row_mode [NUM_ROWS] = '{1, 1, 1, 1, 0, 1, 1}; // Row 4 runs with the update enable low.
    int row_rand [NUM_ROWS] = '{0, 0, 0, 1, 0, 0, 0};

    logic     i_clk;
    logic     i_rst_n;
    logic     i_mode;
    logic     i_clear;
    logic     i_err_valid_pulse;
    logic     i_correct;
    logic     i_flip_valid;
    err_cnt_t i_num_err;
    pos_t     i_err_loc0, i_err_loc1, i_err_loc2, i_err_loc3;
    pos_t     i_flip_pos1, i_flip_pos2;
    pos_t     o_llr_addr0, o_llr_addr1, o_llr_addr2, o_llr_addr3, o_llr_addr4, o_llr_addr5;
    llr_t     i_llr0 = '0, i_llr1 = '0, i_llr2 = '0, i_llr3 = '0, i_llr4 = '0, i_llr5 = '0;
    tp_idx_t  i_rd_sel;
    pos_t     o_rd_pos0, o_rd_pos1, o_rd_pos2, o_rd_pos3, o_rd_pos4, o_rd_pos5;
    err_cnt_t o_rd_cnt;
    tp_cnt_t  o_min_tp;
    logic     o_valid;

    pos_t     model_pos [NUM_TP][NUM_CAND];
    err_cnt_t model_cnt [NUM_TP];
    int       model_tp;
    int       model_used;
    int       model_min_sum;
    int       model_min_tp;
    int       pulses_seen;
    int       since_fourth; // Edges since the fourth accepted pulse and -1 until it comes.
    int       errors;
    int       checks;
    integer   seed = 32'h61f1;

    chase_pattern_saver i_dut (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_mode (i_mode), .i_clear (i_clear),
        .i_err_valid_pulse (i_err_valid_pulse), .i_err_loc0 (i_err_loc0),
        .i_err_loc1 (i_err_loc1), .i_err_loc2 (i_err_loc2), .i_err_loc3 (i_err_loc3),
        .i_num_err (i_num_err), .i_correct (i_correct), .i_flip_pos1 (i_flip_pos1),
        .i_flip_pos2 (i_flip_pos2), .i_flip_valid (i_flip_valid),
        .o_llr_addr0 (o_llr_addr0), .o_llr_addr1 (o_llr_addr1), .o_llr_addr2 (o_llr_addr2),
        .o_llr_addr3 (o_llr_addr3), .o_llr_addr4 (o_llr_addr4), .o_llr_addr5 (o_llr_addr5),
        .i_llr0 (i_llr0), .i_llr1 (i_llr1), .i_llr2 (i_llr2), .i_llr3 (i_llr3),
        .i_llr4 (i_llr4), .i_llr5 (i_llr5), .i_rd_sel (i_rd_sel),
        .o_rd_pos0 (o_rd_pos0), .o_rd_pos1 (o_rd_pos1), .o_rd_pos2 (o_rd_pos2),
        .o_rd_pos3 (o_rd_pos3), .o_rd_pos4 (o_rd_pos4), .o_rd_pos5 (o_rd_pos5),
        .o_rd_cnt (o_rd_cnt), .o_min_tp (o_min_tp), .o_valid (o_valid)
    );

    initial begin
        i_clk = 1'b0;
        forever #CLK_HALF i_clk = ~i_clk;
    end

    // The LLR memory answers with the low address bits one clock after the address.
    always @(posedge i_clk) begin
        i_llr0 <= o_llr_addr0[6:0];
        i_llr1 <= o_llr_addr1[6:0];
        i_llr2 <= o_llr_addr2[6:0];
        i_llr3 <= o_llr_addr3[6:0];
        i_llr4 <= o_llr_addr4[6:0];
        i_llr5 <= o_llr_addr5[6:0];
    end

    function automatic pos_t read_pos(input int c);
        case (c)
            0:       read_pos = o_rd_pos0;
            1:       read_pos = o_rd_pos1;
            2:       read_pos = o_rd_pos2;
            3:       read_pos = o_rd_pos3;
            4:       read_pos = o_rd_pos4;
            default: read_pos = o_rd_pos5;
        endcase
    endfunction

    function automatic pos_t read_addr(input int c);
        case (c)
            0:       read_addr = o_llr_addr0;
            1:       read_addr = o_llr_addr1;
            2:       read_addr = o_llr_addr2;
            3:       read_addr = o_llr_addr3;
            4:       read_addr = o_llr_addr4;
            default: read_addr = o_llr_addr5;
        endcase
    endfunction

    // Unsorted candidate of one slot, masked by the error count and the pattern number.
    function automatic pos_t masked_cand(input int n, input int slot, input int tp);
        case (slot)
            0:       masked_cand = (tbl_ne[n] > 0) ? pos_t'(tbl_l0[n]) : POS_NONE;
            1:       masked_cand = (tbl_ne[n] > 1) ? pos_t'(tbl_l1[n]) : POS_NONE;
            2:       masked_cand = (tbl_ne[n] > 2) ? pos_t'(tbl_l2[n]) : POS_NONE;
            3:       masked_cand = (tbl_ne[n] > 3) ? pos_t'(tbl_l3[n]) : POS_NONE;
            4:       masked_cand = (tp == 1 || tp == 3) ? pos_t'(tbl_f1[n]) : POS_NONE;
            default: masked_cand = (tp == 2 || tp == 3) ? pos_t'(tbl_f2[n]) : POS_NONE;
        endcase
    endfunction

    // One clock; tracks accepted pulses and checks o_valid on the falling edge.
    task automatic step_cycle(input bit check_valid);
        @(posedge i_clk);
        if (since_fourth >= 0)
            since_fourth++;
        if (i_mode && !i_clear && i_err_valid_pulse && pulses_seen < NUM_TP) begin
            pulses_seen++;
            if (pulses_seen == NUM_TP)
                since_fourth = 0;
        end
        @(negedge i_clk);
        if (check_valid) begin
            checks++;
            if (o_valid !== (since_fourth >= 2)) begin
                errors++;
                $display("CHECK FAILED at %0t: o_valid is %b", $time, o_valid);
            end
        end
    endtask

    // Expected merge, sort, store and score of one pattern under the update enable.
    task automatic model_pattern(input int n);
        pos_t cand [NUM_CAND];
        pos_t tmp;
        int   sum;
        int   cnt;
        for (int i = 0; i < NUM_CAND; i++)
            cand[i] = masked_cand(n, i, model_tp);
        sum = 0;
        cnt = 0;
        for (int i = 0; i < NUM_CAND; i++) begin
            if (cand[i] != POS_NONE) begin
                sum += cand[i] % 128; // Memory content is the low seven address bits.
                cnt++;
            end
        end
        for (int i = 0; i < NUM_CAND - 1; i++) begin
            for (int j = 0; j < NUM_CAND - 1 - i; j++) begin
                if (cand[j] > cand[j+1]) begin
                    tmp       = cand[j];
                    cand[j]   = cand[j+1];
                    cand[j+1] = tmp;
                end
            end
        end
        if (tbl_ok[n] != 0 && tbl_fv[n] != 0 && model_used < NUM_TP) begin
            for (int i = 0; i < NUM_CAND; i++)
                model_pos[model_used][i] = cand[i];
            model_cnt[model_used] = err_cnt_t'(cnt);
            if (sum < model_min_sum) begin
                model_min_sum = sum;
                model_min_tp  = model_used + 1;
            end
            model_used++;
        end
        if (model_tp < NUM_TP)
            model_tp++;
    endtask

    task automatic randomize_row(input int r);
        int n;
        for (int p = 0; p < NUM_TP; p++) begin
            n = r * NUM_TP + p;
            tbl_ne[n] = $unsigned($random(seed)) % (MAX_ERR + 1);
            tbl_l0[n] = $unsigned($random(seed)) % 1023;
            tbl_l1[n] = $unsigned($random(seed)) % 1023;
            tbl_l2[n] = $unsigned($random(seed)) % 1023;
            tbl_l3[n] = $unsigned($random(seed)) % 1023;
            tbl_f1[n] = $unsigned($random(seed)) % 1023;
            tbl_f2[n] = $unsigned($random(seed)) % 1023;
        end
    endtask

    task automatic clear_codeword();
        i_mode  = 1'b1;
        i_clear = 1'b1;
        step_cycle(1'b0);
        i_clear = 1'b0;
        repeat (3) step_cycle(1'b0);
        model_tp      = 0;
        model_used    = 0;
        model_min_sum = int'(LLR_SUM_INIT);
        model_min_tp  = 0;
        pulses_seen   = 0;
        since_fourth  = -1;
        checks++;
        if (o_valid !== 1'b0 || o_min_tp !== '0) begin
            errors++;
            $display("CHECK FAILED at %0t: after clear o_valid %b o_min_tp %0d",
                     $time, o_valid, o_min_tp);
        end
    endtask

    task automatic apply_pattern(input int n, input bit mode);
        pos_t exp_addr [NUM_CAND];
        i_mode            = mode;
        i_num_err         = err_cnt_t'(tbl_ne[n]);
        i_err_loc0        = pos_t'(tbl_l0[n]);
        i_err_loc1        = pos_t'(tbl_l1[n]);
        i_err_loc2        = pos_t'(tbl_l2[n]);
        i_err_loc3        = pos_t'(tbl_l3[n]);
        i_flip_pos1       = pos_t'(tbl_f1[n]);
        i_flip_pos2       = pos_t'(tbl_f2[n]);
        i_correct         = (tbl_ok[n] != 0);
        i_flip_valid      = (tbl_fv[n] != 0);
        i_err_valid_pulse = 1'b1;
        for (int i = 0; i < NUM_CAND; i++)
            exp_addr[i] = masked_cand(n, i, model_tp);
        if (mode)
            model_pattern(n);
        step_cycle(1'b1);
        for (int i = 0; i < NUM_CAND; i++) begin
            checks++;
            if (read_addr(i) !== exp_addr[i]) begin
                errors++;
                $display("CHECK FAILED at %0t: pattern %0d addr %0d is %0d expected %0d",
                         $time, n, i, read_addr(i), exp_addr[i]);
            end
        end
        i_err_valid_pulse = 1'b0;
        repeat (tbl_gap[n]) step_cycle(1'b1);
    endtask

    task automatic check_codeword(input int r);
        repeat (2) step_cycle(1'b1); // Scoring lands two edges after the last pulse.
        checks++;
        if (o_min_tp !== tp_cnt_t'(model_min_tp)) begin
            errors++;
            $display("CHECK FAILED at %0t: row %0d o_min_tp %0d expected %0d",
                     $time, r, o_min_tp, model_min_tp);
        end
        for (int s = 0; s < NUM_TP; s++) begin
            i_rd_sel = tp_idx_t'(s);
            step_cycle(1'b1);
            for (int c = 0; c < NUM_CAND; c++) begin
                checks++;
                if (read_pos(c) !== model_pos[s][c]) begin
                    errors++;
                    $display("CHECK FAILED at %0t: row %0d slot %0d pos %0d is %0d expected %0d",
                             $time, r, s, c, read_pos(c), model_pos[s][c]);
                end
            end
            checks++;
            if (o_rd_cnt !== model_cnt[s]) begin
                errors++;
                $display("CHECK FAILED at %0t: row %0d slot %0d count %0d expected %0d",
                         $time, r, s, o_rd_cnt, model_cnt[s]);
            end
        end
    endtask

    initial begin
        int max_gap;
        max_gap = 0;
        for (int n = 0; n < NUM_PAT; n++) begin
            if (tbl_gap[n] > max_gap)
                max_gap = tbl_gap[n];
        end
        repeat (NUM_ROWS * NUM_TP * (max_gap + 6) + 20) @(posedge i_clk);
        $display("Timeout: the test did not finish in the expected number of cycles.");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        i_rst_n           = 1'b0;
        i_mode            = 1'b0;
        i_clear           = 1'b0;
        i_err_valid_pulse = 1'b0;
        i_correct         = 1'b0;
        i_flip_valid      = 1'b0;
        i_num_err         = '0;
        i_err_loc0        = '0;
        i_err_loc1        = '0;
        i_err_loc2        = '0;
        i_err_loc3        = '0;
        i_flip_pos1       = '0;
        i_flip_pos2       = '0;
        i_rd_sel          = '0;
        errors            = 0;
        checks            = 0;
        pulses_seen       = 0;
        since_fourth      = -1;
        for (int s = 0; s < NUM_TP; s++) begin
            model_cnt[s] = '0;
            for (int c = 0; c < NUM_CAND; c++)
                model_pos[s][c] = '0; // Store comes out of reset zeroed.
        end
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_rand[r] != 0)
                randomize_row(r);
            clear_codeword();
            for (int p = 0; p < NUM_TP; p++)
                apply_pattern(r * NUM_TP + p, row_mode[r] != 0);
            check_codeword(r);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
